/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps
TOP       := tb_ls_array
FILELIST  := ls_array.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the simulation prints the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

/* hw/beat_counter.sv */
`include "ls_array_config.svh"

module beat_counter (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_load_array,
    input  logic                   enable_cnt,
    input  logic                   ld_max_cnt,
    input  ls_ctrl_pkg::beat_idx_t max_cnt_from_cu,
    output ls_ctrl_pkg::beat_idx_t beat
);
    import ls_ctrl_pkg::*;

    // wrap point, written by the control unit
    beat_idx_t max_cnt;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            beat    <= '0;
            max_cnt <= '0;
        end else begin
            // count only while the array is active, hold otherwise
            if (enable_load_array) begin
                if (!enable_cnt) begin
                    beat <= '0;
                end else if (beat == max_cnt - 1'b1) begin
                    beat <= '0;
                end else begin
                    beat <= beat + 1'b1;
                end
            end
            if (ld_max_cnt) begin
                max_cnt <= max_cnt_from_cu;
            end
        end
    end

endmodule

/* hw/lane_enable_decoder.sv */
`include "ls_array_config.svh"

module lane_enable_decoder (
    input  logic                     enable_load_array,
    input  ls_ctrl_pkg::precision_e  data_precision,
    output ls_ctrl_pkg::column_mask_t column_mask,
    output ls_ctrl_pkg::row_mask_t    row_mask
);
    import ls_ctrl_pkg::*;

    // element width in bits for a precision code
    function automatic int elem_bits(precision_e prec);
        case (prec)
            prec_int8:  elem_bits = 8;
            prec_int16: elem_bits = 16;
            prec_int32: elem_bits = 32;
            prec_int64: elem_bits = 64;
            default:    elem_bits = 0;
        endcase
    endfunction

    int column_lanes;
    int row_lanes;

    // narrow data packs into fewer lanes, the rest stay quiet
    always_comb begin
        column_lanes = `LS_COLUMNS * elem_bits(data_precision) / `LS_DATA_WIDTH;
        row_lanes    = `LS_ROWS * elem_bits(data_precision) / `LS_DATA_WIDTH;
        for (int i = 0; i < `LS_COLUMNS; i++) begin
            column_mask[i] = enable_load_array && (i < column_lanes);
        end
        for (int i = 0; i < `LS_ROWS; i++) begin
            row_mask[i] = enable_load_array && (i < row_lanes);
        end
    end

endmodule

/* hw/load_bank.sv */
`include "ls_array_config.svh"

module load_bank #(
    parameter int LANES = `LS_COLUMNS
) (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            load,
    input  ls_ctrl_pkg::beat_idx_t          beat,
    input  logic [LANES-1:0]                lane_mask,
    input  ls_data_pkg::word_t              word_in,
    output logic [LANES*`LS_DATA_WIDTH-1:0] lanes_out
);
    import ls_ctrl_pkg::*;

    localparam int W = `LS_DATA_WIDTH;

    ////////////////////////////////////////////////////////////////////////////
    // lane registers
    ////////////////////////////////////////////////////////////////////////////

    // the beat picks one lane per strobe; a masked lane keeps its word
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            lanes_out <= '0;
        end else if (load) begin
            for (int i = 0; i < LANES; i++) begin
                if (lane_mask[i] && (beat == beat_idx_t'(i))) begin
                    lanes_out[i*W +: W] <= word_in;
                end
            end
        end
    end

    // lanes_out drives the matrix unit directly without repacking

endmodule

/* hw/ls_array.sv */
`include "ls_array_config.svh"

module ls_array (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     enable_load_array,
    input  ls_ctrl_pkg::precision_e  data_precision,

    // FIFO and weight memory strobes
    input  logic                     infifo_read,
    input  logic                     outfifo_write,
    input  logic                     read_weight_memory,
    input  logic                     enable_store_activation_data,

    // counter control from the control unit
    input  logic                     enable_cnt,
    input  logic                     ld_max_cnt,
    input  logic                     enable_cnt_weight,
    input  logic                     ld_max_cnt_weight,
    input  logic                     ld_weight_page_cnt,

    input  ls_data_pkg::word_t       input_data_from_fifo,
    input  ls_data_pkg::word_t       data_from_weight_memory,
    input  ls_data_pkg::column_vec_t data_from_mxu,

    input  ls_ctrl_pkg::beat_idx_t   max_cnt_from_cu,
    input  ls_ctrl_pkg::row_idx_t    max_cnt_weight_from_cu,
    input  ls_ctrl_pkg::wm_addr_t    start_value_wm,

    output ls_data_pkg::word_t       data_to_fifo_out,
    output ls_data_pkg::column_vec_t data_to_mxu,
    output ls_data_pkg::row_vec_t    weight_to_mxu,
    output ls_ctrl_pkg::wm_addr_t    wm_address
);
    import ls_ctrl_pkg::*;

    column_mask_t column_mask;
    row_mask_t    row_mask;
    // active lane for every bank
    beat_idx_t    beat;

    ////////////////////////////////////////////////////////////////////////////
    // lane gating and beat
    ////////////////////////////////////////////////////////////////////////////

    lane_enable_decoder i_lane_enable_decoder (
        .enable_load_array (enable_load_array),
        .data_precision    (data_precision),
        .column_mask       (column_mask),
        .row_mask          (row_mask)
    );

    beat_counter i_beat_counter (
        .clk               (clk),
        .reset_n           (reset_n),
        .enable_load_array (enable_load_array),
        .enable_cnt        (enable_cnt),
        .ld_max_cnt        (ld_max_cnt),
        .max_cnt_from_cu   (max_cnt_from_cu),
        .beat              (beat)
    );

    ////////////////////////////////////////////////////////////////////////////
    // activation, weight and result banks
    ////////////////////////////////////////////////////////////////////////////

    load_bank #(
        .LANES (`LS_COLUMNS)
    ) i_activation_bank (
        .clk       (clk),
        .reset_n   (reset_n),
        .load      (infifo_read),
        .beat      (beat),
        .lane_mask (column_mask),
        .word_in   (input_data_from_fifo),
        .lanes_out (data_to_mxu)
    );

    load_bank #(
        .LANES (`LS_ROWS)
    ) i_weight_bank (
        .clk       (clk),
        .reset_n   (reset_n),
        .load      (read_weight_memory),
        .beat      (beat),
        .lane_mask (row_mask),
        .word_in   (data_from_weight_memory),
        .lanes_out (weight_to_mxu)
    );

    store_bank i_store_bank (
        .clk           (clk),
        .reset_n       (reset_n),
        .store         (enable_store_activation_data),
        .outfifo_write (outfifo_write),
        .beat          (beat),
        .column_mask   (column_mask),
        .results_in    (data_from_mxu),
        .fifo_word     (data_to_fifo_out)
    );

    // weight memory addressing runs on its own counters
    weight_address_gen i_weight_address_gen (
        .clk                    (clk),
        .reset_n                (reset_n),
        .enable_load_array      (enable_load_array),
        .enable_cnt_weight      (enable_cnt_weight),
        .ld_max_cnt_weight      (ld_max_cnt_weight),
        .ld_weight_page_cnt     (ld_weight_page_cnt),
        .max_cnt_weight_from_cu (max_cnt_weight_from_cu),
        .start_value_wm         (start_value_wm),
        .wm_address             (wm_address)
    );

endmodule

/* hw/ls_ctrl_pkg.sv */
`include "ls_array_config.svh"

// types for the control side: precision, beat, masks and addressing
package ls_ctrl_pkg;

    // element precision of the data in a lane word
    typedef enum logic [`LS_PRECISION_BITS-1:0] {
        prec_int8  = 0,
        prec_int16 = 1,
        prec_int32 = 2,
        prec_int64 = 3
    } precision_e;

    // beat count and its maximum, one spare bit so the lane count fits
    typedef logic [$clog2(`LS_COLUMNS):0] beat_idx_t;

    // one enable per lane
    typedef logic [`LS_COLUMNS-1:0] column_mask_t;
    typedef logic [`LS_ROWS-1:0] row_mask_t;

    // weight memory address
    typedef logic [`LS_WM_ADDR_WIDTH-1:0] wm_addr_t;

    // row counter of the weight address and its maximum
    typedef logic [$clog2(`LS_ROWS):0] row_idx_t;

endpackage

/* hw/ls_data_pkg.sv */
`include "ls_array_config.svh"

// types for the payload moving between the FIFOs, the weight memory
// and the matrix unit
package ls_data_pkg;

    // one lane word
    typedef logic [`LS_DATA_WIDTH-1:0] word_t;

    // all column lanes side by side, lane 0 in the low word
    typedef logic [`LS_COLUMNS*`LS_DATA_WIDTH-1:0] column_vec_t;

    // all row lanes, same ordering as the columns
    typedef logic [`LS_ROWS*`LS_DATA_WIDTH-1:0] row_vec_t;

endpackage

/* hw/store_bank.sv */
`include "ls_array_config.svh"

module store_bank (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       store,
    input  logic                       outfifo_write,
    input  ls_ctrl_pkg::beat_idx_t     beat,
    input  ls_ctrl_pkg::column_mask_t  column_mask,
    input  ls_data_pkg::column_vec_t   results_in,
    output ls_data_pkg::word_t         fifo_word
);
    import ls_data_pkg::*;

    localparam int W         = `LS_DATA_WIDTH;
    localparam int LANE_BITS = $clog2(`LS_COLUMNS);

    column_vec_t          store_q;
    logic [LANE_BITS-1:0] sel;

    ////////////////////////////////////////////////////////////////////////////
    // result capture
    ////////////////////////////////////////////////////////////////////////////

    // one full row per strobe, idle lanes keep old results
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            store_q <= '0;
        end else if (store) begin
            for (int i = 0; i < `LS_COLUMNS; i++) begin
                if (column_mask[i]) begin
                    store_q[i*W +: W] <= results_in[i*W +: W];
                end
            end
        end
    end

    // readout, one lane per beat
    assign sel = beat[LANE_BITS-1:0];

    always_comb begin
        fifo_word = '0;
        if (outfifo_write && (beat < `LS_COLUMNS)) begin
            fifo_word = store_q[sel*W +: W];
        end
    end

endmodule

/* hw/weight_address_gen.sv */
`include "ls_array_config.svh"

module weight_address_gen (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  enable_load_array,
    input  logic                  enable_cnt_weight,
    input  logic                  ld_max_cnt_weight,
    input  logic                  ld_weight_page_cnt,
    input  ls_ctrl_pkg::row_idx_t max_cnt_weight_from_cu,
    input  ls_ctrl_pkg::wm_addr_t start_value_wm,
    output ls_ctrl_pkg::wm_addr_t wm_address
);
    import ls_ctrl_pkg::*;

    localparam int ROW_BITS  = $clog2(`LS_ROWS);
    localparam int PAGE_BITS = `LS_WM_ADDR_WIDTH - ROW_BITS;

    row_idx_t             row_cnt;
    row_idx_t             max_cnt_weight;
    logic [PAGE_BITS-1:0] page_cnt;
    wm_addr_t             cur_addr;

    // page in the high bits, row in the low bits
    assign cur_addr = {page_cnt, row_cnt[ROW_BITS-1:0]};

    ////////////////////////////////////////////////////////////////////////////
    // row and page counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            row_cnt        <= '0;
            max_cnt_weight <= '0;
            page_cnt       <= '0;
        end else begin
            if (enable_load_array && enable_cnt_weight) begin
                // last word of the memory, start over from address 0
                if (cur_addr == wm_addr_t'(`LS_WM_SIZE - 1)) begin
                    row_cnt  <= '0;
                    page_cnt <= '0;
                end else if (row_cnt == max_cnt_weight - 1'b1) begin
                    row_cnt  <= '0;
                    page_cnt <= page_cnt + 1'b1;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end
            if (ld_max_cnt_weight) begin
                max_cnt_weight <= max_cnt_weight_from_cu;
            end
            // preload wins over the increment above
            if (ld_weight_page_cnt) begin
                page_cnt <= start_value_wm[`LS_WM_ADDR_WIDTH-1:ROW_BITS];
            end
        end
    end

    assign wm_address = enable_cnt_weight ? cur_addr : '0;

endmodule

/* include/ls_array_config.svh */
`ifndef LS_ARRAY_CONFIG_SVH
`define LS_ARRAY_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// load/store array sizes
////////////////////////////////////////////////////////////////////////////

// width of one lane word, also the widest precision
`define LS_DATA_WIDTH 64

// activation and store lanes, one per matrix unit column
`define LS_COLUMNS 8

// weight lanes, one per matrix unit row
`define LS_ROWS 8

// weight memory addressing
`define LS_WM_ADDR_WIDTH 32
// number of words before the address wraps
`define LS_WM_SIZE 2048

// precision code width, int8 up to int64
`define LS_PRECISION_BITS 2

`endif

/* ls_array.f */
+incdir+include
hw/ls_data_pkg.sv
hw/ls_ctrl_pkg.sv
hw/lane_enable_decoder.sv
hw/beat_counter.sv
hw/load_bank.sv
hw/store_bank.sv
hw/weight_address_gen.sv
hw/ls_array.sv
test/tb_ls_array.sv

/* test/tb_ls_array.sv */
`include "ls_array_config.svh"

module tb_ls_array;
    timeunit 1ns;
    timeprecision 1ps;

    import ls_data_pkg::*;
    import ls_ctrl_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int TIMEOUT_CYCLES = 400;
    localparam int RANDOM_SEED    = 81821;
    localparam int W              = `LS_DATA_WIDTH;

    logic        clk;
    logic        reset_n;
    logic        enable_load_array;
    precision_e  data_precision;
    logic        infifo_read;
    logic        outfifo_write;
    logic        read_weight_memory;
    logic        enable_store_activation_data;
    logic        enable_cnt;
    logic        ld_max_cnt;
    logic        enable_cnt_weight;
    logic        ld_max_cnt_weight;
    logic        ld_weight_page_cnt;
    word_t       input_data_from_fifo;
    word_t       data_from_weight_memory;
    column_vec_t data_from_mxu;
    beat_idx_t   max_cnt_from_cu;
    row_idx_t    max_cnt_weight_from_cu;
    wm_addr_t    start_value_wm;
    word_t       data_to_fifo_out;
    column_vec_t data_to_mxu;
    row_vec_t    weight_to_mxu;
    wm_addr_t    wm_address;

    int errors = 0;
    int errors_at_start = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycle_count = 0;

    // reference copies of the lane registers
    column_vec_t exp_columns;
    row_vec_t    exp_rows;

    ls_array i_ls_array (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped: cycle limit of %0d reached before the tests ended", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    // lanes in use, element width doubles per precision code
    function automatic int active_lane_count(input precision_e prec, input int lanes);
        return lanes * (8 << int'(prec)) / W;
    endfunction

    function automatic word_t random_word();
        return {$urandom, $urandom};
    endfunction

    task automatic check_word(input string test, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h", test, expected, actual);
        end
    endtask

    task automatic check_columns(input string test, input column_vec_t expected,
                                 input column_vec_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h", test, expected, actual);
        end
    endtask

    task automatic check_rows(input string test, input row_vec_t expected,
                              input row_vec_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h", test, expected, actual);
        end
    endtask

    task automatic check_addr(input string test, input wm_addr_t expected,
                              input wm_addr_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h", test, expected, actual);
        end
    endtask

    task automatic end_test(input string test);
        int n;
        n = errors - errors_at_start;
        if (n == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("%s: %s, %0d errors", test, (n == 0) ? "passed" : "failed", n);
        errors_at_start = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        exp_columns = '0;
        exp_rows    = '0;
        @(negedge clk);
        check_columns("reset_state", exp_columns, data_to_mxu);
        check_rows("reset_state", exp_rows, weight_to_mxu);
        check_word("reset_state", '0, data_to_fifo_out);
        check_addr("reset_state", '0, wm_address);
        end_test("reset_state");
    endtask

    task automatic test_activation_load();
        int    n;
        word_t word;
        for (int p = 0; p < 4; p++) begin
            // the setup edge clears the beat and loads the maximum
            @(posedge clk);
            enable_load_array <= 1'b1;
            data_precision    <= precision_e'(p);
            ld_max_cnt        <= 1'b1;
            max_cnt_from_cu   <= beat_idx_t'(`LS_COLUMNS);
            enable_cnt        <= 1'b0;
            n = active_lane_count(precision_e'(p), `LS_COLUMNS);
            for (int k = 0; k < `LS_COLUMNS; k++) begin
                @(posedge clk);
                word = random_word();
                ld_max_cnt           <= 1'b0;
                enable_cnt           <= 1'b1;
                infifo_read          <= 1'b1;
                input_data_from_fifo <= word;
                if (k < n) begin
                    exp_columns[k*W +: W] = word;
                end
            end
            @(posedge clk);
            infifo_read <= 1'b0;
            enable_cnt  <= 1'b0;
            @(negedge clk);
            check_columns("activation_load", exp_columns, data_to_mxu);
        end
        end_test("activation_load");
    endtask

    task automatic test_weight_load();
        int    n;
        word_t word;
        @(posedge clk);
        enable_load_array <= 1'b1;
        data_precision    <= prec_int32;
        ld_max_cnt        <= 1'b1;
        max_cnt_from_cu   <= beat_idx_t'(4);
        enable_cnt        <= 1'b0;
        n = active_lane_count(prec_int32, `LS_ROWS);
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            word = random_word();
            ld_max_cnt              <= 1'b0;
            enable_cnt              <= 1'b1;
            read_weight_memory      <= 1'b1;
            data_from_weight_memory <= word;
            if (k < n) begin
                exp_rows[k*W +: W] = word;
            end
        end
        @(posedge clk);
        read_weight_memory <= 1'b0;
        enable_cnt         <= 1'b0;
        @(negedge clk);
        check_rows("weight_load", exp_rows, weight_to_mxu);
        end_test("weight_load");
    endtask

    task automatic test_store_readout();
        column_vec_t results;
        int          exp_beat;
        for (int i = 0; i < `LS_COLUMNS; i++) begin
            results[i*W +: W] = random_word();
        end
        @(posedge clk);
        enable_load_array            <= 1'b1;
        data_precision               <= prec_int64;
        ld_max_cnt                   <= 1'b1;
        max_cnt_from_cu              <= beat_idx_t'(`LS_COLUMNS);
        enable_cnt                   <= 1'b0;
        enable_store_activation_data <= 1'b1;
        data_from_mxu                <= results;
        // capture edge, the beat also clears here
        @(posedge clk);
        enable_store_activation_data <= 1'b0;
        ld_max_cnt                   <= 1'b0;
        outfifo_write                <= 1'b1;
        enable_cnt                   <= 1'b1;
        exp_beat = 0;
        for (int k = 0; k < `LS_COLUMNS + 2; k++) begin
            @(negedge clk);
            check_word("store_readout", results[exp_beat*W +: W], data_to_fifo_out);
            @(posedge clk);
            exp_beat = (exp_beat == `LS_COLUMNS - 1) ? 0 : exp_beat + 1;
        end
        outfifo_write <= 1'b0;
        enable_cnt    <= 1'b0;
        @(negedge clk);
        check_word("store_readout", '0, data_to_fifo_out);
        end_test("store_readout");
    endtask

    task automatic test_address_sequence();
        int row;
        int page;
        int addr;
        @(posedge clk);
        enable_load_array      <= 1'b1;
        enable_cnt_weight      <= 1'b0;
        ld_max_cnt_weight      <= 1'b1;
        max_cnt_weight_from_cu <= row_idx_t'(8);
        ld_weight_page_cnt     <= 1'b1;
        start_value_wm         <= wm_addr_t'(255 * `LS_ROWS);
        @(posedge clk);
        ld_max_cnt_weight  <= 1'b0;
        ld_weight_page_cnt <= 1'b0;
        enable_cnt_weight  <= 1'b1;
        row  = 0;
        page = 255;
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            addr = page * `LS_ROWS + row;
            check_addr("address_sequence", wm_addr_t'(addr), wm_address);
            @(posedge clk);
            // end of memory clears both counters
            if (addr == `LS_WM_SIZE - 1) begin
                row  = 0;
                page = 0;
            end else if (row == 8 - 1) begin
                row = 0;
                page++;
            end else begin
                row++;
            end
        end
        enable_cnt_weight <= 1'b0;
        @(negedge clk);
        check_addr("address_sequence", '0, wm_address);
        end_test("address_sequence");
    endtask

    task automatic test_idle_array();
        word_t word;
        @(posedge clk);
        enable_load_array <= 1'b1;
        data_precision    <= prec_int64;
        ld_max_cnt        <= 1'b1;
        max_cnt_from_cu   <= beat_idx_t'(`LS_COLUMNS);
        enable_cnt        <= 1'b0;
        @(posedge clk);
        ld_max_cnt <= 1'b0;
        enable_cnt <= 1'b1;
        // three counting edges leave the beat on lane 3
        repeat (3) @(posedge clk);
        enable_load_array  <= 1'b0;
        infifo_read        <= 1'b1;
        read_weight_memory <= 1'b1;
        for (int k = 0; k < 5; k++) begin
            @(posedge clk);
            input_data_from_fifo    <= random_word();
            data_from_weight_memory <= random_word();
        end
        @(negedge clk);
        check_columns("idle_array", exp_columns, data_to_mxu);
        check_rows("idle_array", exp_rows, weight_to_mxu);
        // one active load shows where the beat stopped
        @(posedge clk);
        word = random_word();
        enable_load_array    <= 1'b1;
        read_weight_memory   <= 1'b0;
        input_data_from_fifo <= word;
        exp_columns[3*W +: W] = word;
        @(posedge clk);
        infifo_read <= 1'b0;
        enable_cnt  <= 1'b0;
        @(negedge clk);
        check_columns("idle_array", exp_columns, data_to_mxu);
        end_test("idle_array");
    endtask

    initial begin
        void'($urandom(RANDOM_SEED));
        reset_n                      <= 1'b0;
        enable_load_array            <= 1'b0;
        data_precision               <= prec_int8;
        infifo_read                  <= 1'b0;
        outfifo_write                <= 1'b0;
        read_weight_memory           <= 1'b0;
        enable_store_activation_data <= 1'b0;
        enable_cnt                   <= 1'b0;
        ld_max_cnt                   <= 1'b0;
        enable_cnt_weight            <= 1'b0;
        ld_max_cnt_weight            <= 1'b0;
        ld_weight_page_cnt           <= 1'b0;
        input_data_from_fifo         <= '0;
        data_from_weight_memory      <= '0;
        data_from_mxu                <= '0;
        max_cnt_from_cu              <= '0;
        max_cnt_weight_from_cu       <= '0;
        start_value_wm               <= '0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        test_reset_state();
        test_activation_load();
        test_weight_load();
        test_store_readout();
        test_address_sequence();
        test_idle_array();

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
